// ==== Bender.yml ====
package:
  name: ddr_ctrl

sources:
  - files:
      - source/ddr_pkg.sv
      - source/refresh_timer.sv
      - source/dq_lane_serializer.sv
      - source/bank_sequencer.sv
      - source/ddr_ctrl_top.sv
  - target: test
    files:
      - verification/ddr_checker.sv
      - verification/tb_ddr_ctrl.sv

// ==== verilog.f ====
source/ddr_pkg.sv
source/refresh_timer.sv
source/dq_lane_serializer.sv
source/bank_sequencer.sv
source/ddr_ctrl_top.sv
verification/ddr_checker.sv
verification/tb_ddr_ctrl.sv

// ==== verification/tb_ddr_ctrl.sv ====
`timescale 1ns/100ps

module tb_ddr_ctrl import ddr_pkg::*; ();

    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = 2 * T_REFI;
    localparam int WAIT_READY     = 0;
    localparam int WAIT_RESPONSE  = 1;
    localparam int WAIT_WRITE     = 2;
    localparam int WAIT_REFRESH   = 3;

    logic                     ddr_clock;
    logic                     rst;
    logic                     cmd_valid;
    ddr_req_t                 cmd;
    burst_t                   wdata;
    logic                     cmd_ready;
    logic                     rsp_valid;
    burst_t                   rsp_data;
    logic                     cke;
    logic                     cs_n;
    logic                     ras_n;
    logic                     cas_n;
    logic                     we_n;
    logic [BANK_BITS-1:0]     ba;
    logic [ADDR_PIN_BITS-1:0] addr;
    logic                     odt;
    logic [DATA_BITS-1:0]     dq_out [NUM_LANES];
    logic [DATA_BITS-1:0]     dq_in [BURST_LENGTH];
    logic                     data_write;

    // Stimulus table
    string    test_names [NUM_TESTS];
    ddr_req_t test_reqs [NUM_TESTS];
    burst_t   test_wdata [NUM_TESTS];
    burst_t   test_rdata [NUM_TESTS];

    // Entry under test as read by the checker
    string    cur_name;
    ddr_req_t cur_req;
    burst_t   cur_wdata;
    burst_t   cur_rdata;

    logic [31:0] lfsr_state = 32'h9548dc37;
    logic        timed_out;

    ddr_ctrl_top i_ddr_ctrl_top (
        .ddr_clock_i (ddr_clock),
        .rst_i       (rst),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .wdata_i     (wdata),
        .cmd_ready_o (cmd_ready),
        .rsp_valid_o (rsp_valid),
        .rsp_data_o  (rsp_data),
        .ddr3_cke_o  (cke),
        .ddr3_cs_n_o (cs_n),
        .ddr3_ras_n_o(ras_n),
        .ddr3_cas_n_o(cas_n),
        .ddr3_we_n_o (we_n),
        .ddr3_ba_o   (ba),
        .ddr3_addr_o (addr),
        .ddr3_odt_o  (odt),
        .ddr3_dq_o   (dq_out),
        .ddr3_dq_i   (dq_in),
        .data_write_o(data_write)
    );

    ddr_checker i_ddr_checker (
        .ddr_clock_i (ddr_clock),
        .rst_i       (rst),
        .cmd_ready_i (cmd_ready),
        .rsp_valid_i (rsp_valid),
        .rsp_data_i  (rsp_data),
        .cke_i       (cke),
        .pin_cmd_i   ({cs_n, ras_n, cas_n, we_n}),
        .ba_i        (ba),
        .addr_i      (addr),
        .odt_i       (odt),
        .dq_i        (dq_out),
        .data_write_i(data_write)
    );

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_burst(output burst_t b);
        for (int i = 0; i < BURST_BITS; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b[i]       = lfsr_state[0];
        end
    endtask

    task automatic set_entry(int idx, string name, logic write, logic [BANK_BITS-1:0] bank,
                             logic [ROW_BITS-1:0] row, logic [COL_BITS-1:0] col,
                             burst_t rdata);
        test_names[idx] = name;
        test_reqs[idx]  = {write, bank, row, col};
        random_burst(test_wdata[idx]);
        test_rdata[idx] = rdata;
    endtask

    task automatic wait_done(int kind);
        logic started;
        logic done;
        started = 1'b0;
        done    = 1'b0;
        for (int n = 0; n < TIMEOUT_CYCLES && !done; n++) begin
            @(posedge ddr_clock);
            case (kind)
                WAIT_READY:    done = cmd_ready;
                WAIT_RESPONSE: done = rsp_valid;
                WAIT_REFRESH:  done = {cs_n, ras_n, cas_n, we_n} == CMD_REFRESH;
                default:       done = started && !data_write;  // Falling edge of write data
            endcase
            started = started || data_write;
        end
        if (!done) begin
            $display("Test %s timed out waiting for the DUT", cur_name);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        ddr_clock = 1'b0;
        forever #2 ddr_clock = ~ddr_clock;
    end

    // Memory model holds the read burst on DQ from READ until the response
    always @(posedge ddr_clock) begin
        if ({cs_n, ras_n, cas_n, we_n} == CMD_READ) begin
            #0.5;
            for (int b = 0; b < BURST_LENGTH; b++) begin
                dq_in[b] = cur_rdata[b*DATA_BITS +: DATA_BITS];
            end
        end else if (rsp_valid) begin
            #0.5;
            for (int b = 0; b < BURST_LENGTH; b++) begin
                dq_in[b] = '0;
            end
        end
    end

    initial begin
        int gap_start;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        wdata     = '0;
        timed_out = 1'b0;
        cur_name  = "reset";
        cur_req   = '0;
        cur_wdata = '0;
        cur_rdata = '0;
        for (int b = 0; b < BURST_LENGTH; b++) begin
            dq_in[b] = '0;
        end

        set_entry(0, "write_bank0", 1'b1, 3'd0, 14'h0123, 10'h010, '0);
        set_entry(1, "read_bank0", 1'b0, 3'd0, 14'h0123, 10'h010,
                  128'hbeef_0007_cafe_0005_f00d_0003_d00d_0001);
        set_entry(2, "write_bank5", 1'b1, 3'd5, 14'h3fff, 10'h3ff, '0);
        set_entry(3, "read_bank7", 1'b0, 3'd7, 14'h2aaa, 10'h155,
                  128'h8001_4002_2004_1008_0810_0420_0240_0180);
        set_entry(4, "write_bank2", 1'b1, 3'd2, 14'h1555, 10'h2aa, '0);
        set_entry(5, "read_bank3", 1'b0, 3'd3, 14'h0000, 10'h000,
                  128'hffff_0000_a5a5_5a5a_1234_5678_9abc_def0);

        repeat (3) @(posedge ddr_clock);
        #0.5 rst = 1'b0;
        wait_done(WAIT_READY);

        for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
            #0.5;
            // Last request is held from just after a REFRESH that ends an idle gap
            if (i == NUM_TESTS - 1) begin
                cur_name  = "refresh_gap";
                gap_start = i_ddr_checker.refresh_count;
                repeat (3 * T_REFI) @(posedge ddr_clock);
                wait_done(WAIT_REFRESH);
                #0.5 i_ddr_checker.close_refresh_gap(gap_start);
            end
            cur_name  = test_names[i];
            cur_req   = test_reqs[i];
            cur_wdata = test_wdata[i];
            cur_rdata = test_rdata[i];
            cmd_valid = 1'b1;
            cmd       = test_reqs[i];
            wdata     = test_wdata[i];
            wait_done(WAIT_READY);
            #0.5 cmd_valid = 1'b0;
            if (!timed_out) begin
                wait_done(test_reqs[i].write ? WAIT_WRITE : WAIT_RESPONSE);
            end
        end

        #0.5;
        cur_name = "flow_control";
        i_ddr_checker.summarize(NUM_TESTS);
        if (timed_out || i_ddr_checker.error_count != 0) begin
            $display(">>> FAIL");
        end else begin
            $display(">>> PASS");
        end
        $finish;
    end

endmodule

// ==== verification/ddr_checker.sv ====
`timescale 1ns/100ps

module ddr_checker import ddr_pkg::*; (
    input  logic                     ddr_clock_i,
    input  logic                     rst_i,
    input  logic                     cmd_ready_i,
    input  logic                     rsp_valid_i,
    input  burst_t                   rsp_data_i,
    input  logic                     cke_i,
    input  ddr_pin_cmd_t             pin_cmd_i,
    input  logic [BANK_BITS-1:0]     ba_i,
    input  logic [ADDR_PIN_BITS-1:0] addr_i,
    input  logic                     odt_i,
    input  logic [DATA_BITS-1:0]     dq_i [NUM_LANES],
    input  logic                     data_write_i
);

    int   cycle          = 0;
    int   since_rst      = 0;   // Cycles since rst_i dropped
    int   test_errors    = 0;
    int   error_count    = 0;
    int   pass_count     = 0;
    int   fail_count     = 0;
    int   activate_count = 0;
    int   refresh_count  = 0;
    int   last_activate  = 0;
    int   last_refresh   = -1;
    int   last_read      = 0;
    int   last_write     = -CAS_WRITE_LATENCY - HALF_BURST;
    int   wr_beat        = 0;
    logic op_active      = 1'b0;
    logic write_q        = 1'b0;
    logic write_window;
    logic rst_q;

    task automatic check_value(string what, logic [BURST_BITS-1:0] expected,
                               logic [BURST_BITS-1:0] actual);
        if (expected !== actual) begin
            $display("Error %s %s expected %0h actual %0h", tb_ddr_ctrl.cur_name, what,
                     expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_problem(string msg);
        $display("Test %s: %s", tb_ddr_ctrl.cur_name, msg);
        test_errors++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("Test %s passed", tb_ddr_ctrl.cur_name);
            pass_count++;
        end else begin
            $display("Test %s failed with %0d errors", tb_ddr_ctrl.cur_name, test_errors);
            fail_count++;
        end
        error_count += test_errors;
        test_errors = 0;
    endtask

    task automatic check_startup(logic cke_expected);
        check_value("cmd_ready_o", 0, cmd_ready_i);
        check_value("rsp_valid_o", 0, rsp_valid_i);
        check_value("data_write_o", 0, data_write_i);
        check_value("ddr3_odt_o", 0, odt_i);
        check_value("ddr3_cke_o", cke_expected, cke_i);
        check_value("pin command", CMD_NOP, pin_cmd_i);
    endtask

    task automatic close_refresh_gap(int start_count);
        if (refresh_count - start_count < 2) begin
            report_problem("fewer than two REFRESH commands during the idle gap");
        end
        finish_test();
    endtask

    task automatic summarize(int expected_activates);
        if (activate_count != expected_activates) begin
            report_problem($sformatf("%0d ACTIVATE commands for %0d requests",
                                     activate_count, expected_activates));
        end
        finish_test();
        $display("Tests passed %0d failed %0d", pass_count, fail_count);
    endtask

    always @(posedge ddr_clock_i) begin
        cycle++;
        if (rst_i) begin
            if (rst_q === 1'b1) begin
                check_startup(1'b0);
            end
            since_rst = 0;
        end else begin
            since_rst++;
        end
        rst_q = rst_i;

        case (since_rst)
            1: check_startup(1'b0);
            2: check_startup(1'b1);     // CKE up, ready still low
            3: begin
                check_value("cmd_ready_o", 1, cmd_ready_i);
                finish_test();
            end
            default: ;
        endcase

        if (since_rst >= 1) begin
            if (pin_cmd_i == CMD_NOP && (ba_i != '0 || addr_i != '0)) begin
                report_problem("address pins not zero in a NOP cycle");
            end
            if (pin_cmd_i == CMD_ACTIVATE) begin
                if (op_active) begin
                    report_problem("ACTIVATE issued while the sequencer was busy");
                end
                if (last_refresh >= 0 && cycle - last_refresh < T_RFC) begin
                    report_problem("ACTIVATE issued within tRFC of a REFRESH");
                end
                check_value("bank", tb_ddr_ctrl.cur_req.bank, ba_i);
                check_value("row", tb_ddr_ctrl.cur_req.row, addr_i);
                activate_count++;
                last_activate = cycle;
                op_active     = 1'b1;
            end
            if (pin_cmd_i == CMD_READ || pin_cmd_i == CMD_WRITE) begin
                check_value("tRCD cycles", T_RCD, cycle - last_activate);
                check_value("write command", tb_ddr_ctrl.cur_req.write, pin_cmd_i == CMD_WRITE);
                check_value("bank", tb_ddr_ctrl.cur_req.bank, ba_i);
                // Column plus auto precharge on A10
                check_value("column address",
                            ADDR_PIN_BITS'(tb_ddr_ctrl.cur_req.col) | ADDR_PIN_BITS'(1 << 10),
                            addr_i);
                if (pin_cmd_i == CMD_WRITE) begin
                    last_write = cycle;
                end else begin
                    last_read = cycle;
                end
                wr_beat = 0;
            end
            if (pin_cmd_i == CMD_REFRESH) begin
                if (last_refresh >= 0 && cycle - last_refresh < T_REFI) begin
                    report_problem("REFRESH commands closer together than tREFI");
                end
                if (op_active) begin
                    report_problem("REFRESH issued during an operation");
                end
                last_refresh = cycle;
                refresh_count++;
            end

            // Beats start CWL cycles after WRITE
            write_window = cycle - last_write >= CAS_WRITE_LATENCY &&
                           cycle - last_write < CAS_WRITE_LATENCY + HALF_BURST;
            check_value("data_write_o", write_window, data_write_i);
            check_value("ddr3_odt_o", write_window, odt_i);
            if (data_write_i) begin
                if (wr_beat >= HALF_BURST) begin
                    report_problem("more write beats than one burst holds");
                end else begin
                    check_value("lane 0 beat",
                                tb_ddr_ctrl.cur_wdata[(2*wr_beat)*DATA_BITS +: DATA_BITS],
                                dq_i[0]);
                    check_value("lane 1 beat",
                                tb_ddr_ctrl.cur_wdata[(2*wr_beat+1)*DATA_BITS +: DATA_BITS],
                                dq_i[1]);
                end
                wr_beat++;
            end else if (write_q) begin     // Last write beat just left
                check_value("write beat count", HALF_BURST, wr_beat);
                op_active = 1'b0;
                finish_test();
            end
            write_q = data_write_i;

            if (rsp_valid_i) begin
                // Burst sampled CL + 1 + BL/2 after READ, response one cycle later
                check_value("read latency", CAS_READ_LATENCY + 1 + HALF_BURST + 1,
                            cycle - last_read);
                check_value("read burst", tb_ddr_ctrl.cur_rdata, rsp_data_i);
                op_active = 1'b0;
                finish_test();
            end
        end
    end

endmodule

// ==== source/ddr_ctrl_top.sv ====
`timescale 1ns/100ps

module ddr_ctrl_top import ddr_pkg::*; (
    input  logic                     ddr_clock_i,
    input  logic                     rst_i,

    input  logic                     cmd_valid_i,
    input  ddr_req_t                 cmd_i,
    input  burst_t                   wdata_i,
    output logic                     cmd_ready_o,
    output logic                     rsp_valid_o,
    output burst_t                   rsp_data_o,

    output logic                     ddr3_cke_o,
    output logic                     ddr3_cs_n_o,
    output logic                     ddr3_ras_n_o,
    output logic                     ddr3_cas_n_o,
    output logic                     ddr3_we_n_o,
    output logic [BANK_BITS-1:0]     ddr3_ba_o,
    output logic [ADDR_PIN_BITS-1:0] ddr3_addr_o,
    output logic                     ddr3_odt_o,
    output logic [DATA_BITS-1:0]     ddr3_dq_o [NUM_LANES],
    input  logic [DATA_BITS-1:0]     ddr3_dq_i [BURST_LENGTH],
    output logic                     data_write_o
);

    ddr_pin_cmd_t pin_cmd;
    logic         refresh_req;
    logic         refresh_ack;
    logic         lane_load;
    burst_t       lane_data;

    assign ddr3_cs_n_o  = pin_cmd.cs_n;
    assign ddr3_ras_n_o = pin_cmd.ras_n;
    assign ddr3_cas_n_o = pin_cmd.cas_n;
    assign ddr3_we_n_o  = pin_cmd.we_n;

    bank_sequencer i_bank_sequencer (
        .ddr_clock_i   (ddr_clock_i),
        .rst_i         (rst_i),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_i         (cmd_i),
        .wdata_i       (wdata_i),
        .refresh_req_i (refresh_req),
        .dq_i          (ddr3_dq_i),
        .cmd_ready_o   (cmd_ready_o),
        .refresh_ack_o (refresh_ack),
        .pin_cmd_o     (pin_cmd),
        .ba_o          (ddr3_ba_o),
        .addr_o        (ddr3_addr_o),
        .cke_o         (ddr3_cke_o),
        .odt_o         (ddr3_odt_o),
        .data_write_o  (data_write_o),
        .lane_load_o   (lane_load),
        .lane_data_o   (lane_data),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_data_o    (rsp_data_o)
    );

    refresh_timer i_refresh_timer (
        .ddr_clock_i   (ddr_clock_i),
        .rst_i         (rst_i),
        .refresh_ack_i (refresh_ack),
        .refresh_req_o (refresh_req)
    );

    // Lane 0 carries even beats, lane 1 odd beats
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        dq_lane_serializer #(.LANE_INDEX(g)) i_dq_lane_serializer (
            .ddr_clock_i (ddr_clock_i),
            .rst_i       (rst_i),
            .load_i      (lane_load),
            .burst_i     (lane_data),
            .dq_o        (ddr3_dq_o[g])
        );
    end

endmodule

// ==== source/bank_sequencer.sv ====
`timescale 1ns/100ps

module bank_sequencer import ddr_pkg::*; (
    input  logic                     ddr_clock_i,
    input  logic                     rst_i,

    input  logic                     cmd_valid_i,
    input  ddr_req_t                 cmd_i,
    input  burst_t                   wdata_i,
    input  logic                     refresh_req_i,
    input  logic [DATA_BITS-1:0]     dq_i [BURST_LENGTH],

    output logic                     cmd_ready_o,
    output logic                     refresh_ack_o,
    output ddr_pin_cmd_t             pin_cmd_o,
    output logic [BANK_BITS-1:0]     ba_o,
    output logic [ADDR_PIN_BITS-1:0] addr_o,
    output logic                     cke_o,
    output logic                     odt_o,
    output logic                     data_write_o,
    output logic                     lane_load_o,
    output burst_t                   lane_data_o,
    output logic                     rsp_valid_o,
    output burst_t                   rsp_data_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ACTIVATE,
        S_OP,
        S_READ,
        S_READ_END,
        S_WRITE,
        S_WRITE_END
    } seq_state_t;

    seq_state_t           state;
    logic [WAIT_BITS-1:0] wait_cnt;
    logic                 init_done;    // One cycle behind CKE
    logic                 accept;
    ddr_req_t             req_q;

    assign cmd_ready_o = init_done && state == S_IDLE && wait_cnt == '0 && !refresh_req_i;
    assign accept      = cmd_valid_i && cmd_ready_o;

    always_ff @(posedge ddr_clock_i) begin
        if (rst_i) begin
            state         <= S_IDLE;
            wait_cnt      <= '0;
            cke_o         <= 1'b0;
            init_done     <= 1'b0;
            pin_cmd_o     <= CMD_NOP;
            ba_o          <= '0;
            addr_o        <= '0;
            odt_o         <= 1'b0;
            data_write_o  <= 1'b0;
            lane_load_o   <= 1'b0;
            rsp_valid_o   <= 1'b0;
            refresh_ack_o <= 1'b0;
        end else begin
            cke_o     <= 1'b1;
            init_done <= cke_o;

            // NOP with zero address unless a command is issued below
            pin_cmd_o     <= CMD_NOP;
            ba_o          <= '0;
            addr_o        <= '0;
            lane_load_o   <= 1'b0;
            rsp_valid_o   <= 1'b0;
            refresh_ack_o <= 1'b0;

            // First beat leaves the serializers the cycle after the load
            if (lane_load_o) begin
                data_write_o <= 1'b1;
                odt_o        <= 1'b1;
            end

            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else begin
                case (state)
                    S_IDLE: begin
                        if (init_done && refresh_req_i) begin
                            pin_cmd_o     <= CMD_REFRESH;
                            refresh_ack_o <= 1'b1;
                            wait_cnt      <= WAIT_BITS'(T_RFC);
                        end else if (accept) begin
                            pin_cmd_o <= CMD_ACTIVATE;
                            ba_o      <= cmd_i.bank;
                            addr_o    <= ADDR_PIN_BITS'(cmd_i.row);
                            state     <= S_ACTIVATE;
                        end
                    end
                    S_ACTIVATE: begin
                        // ACTIVATE is already on the pins
                        state    <= S_OP;
                        wait_cnt <= WAIT_BITS'(T_RCD - 2);
                    end
                    S_OP: begin
                        ba_o       <= req_q.bank;
                        addr_o     <= ADDR_PIN_BITS'(req_q.col);
                        addr_o[10] <= 1'b1;             // Auto precharge
                        if (req_q.write) begin
                            pin_cmd_o <= CMD_WRITE;
                            state     <= S_WRITE;
                            wait_cnt  <= WAIT_BITS'(CAS_WRITE_LATENCY - 2);
                        end else begin
                            pin_cmd_o <= CMD_READ;
                            state     <= S_READ;
                            wait_cnt  <= WAIT_BITS'(CAS_READ_LATENCY);
                        end
                    end
                    S_WRITE: begin
                        lane_load_o <= 1'b1;
                        state       <= S_WRITE_END;
                        wait_cnt    <= WAIT_BITS'(HALF_BURST);
                    end
                    S_WRITE_END: begin
                        data_write_o <= 1'b0;
                        odt_o        <= 1'b0;
                        state        <= S_IDLE;
                        wait_cnt     <= WAIT_BITS'(T_RP + T_WR);
                    end
                    S_READ: begin
                        state    <= S_READ_END;
                        wait_cnt <= WAIT_BITS'(HALF_BURST);
                    end
                    S_READ_END: begin
                        rsp_valid_o <= 1'b1;
                        state       <= S_IDLE;
                        wait_cnt    <= WAIT_BITS'(T_RP);
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // Request and burst payloads
    always_ff @(posedge ddr_clock_i) begin
        if (accept) begin
            req_q       <= cmd_i;
            lane_data_o <= wdata_i;
        end
        if (state == S_READ_END && wait_cnt == '0) begin
            for (int b = 0; b < BURST_LENGTH; b++) begin
                rsp_data_o[b*DATA_BITS +: DATA_BITS] <= dq_i[b];
            end
        end
    end

endmodule

// ==== source/dq_lane_serializer.sv ====
`timescale 1ns/100ps

// LANE_INDEX 0 takes the even beats, 1 the odd ones
module dq_lane_serializer import ddr_pkg::*; #(
    parameter int LANE_INDEX = 0
) (
    input  logic                 ddr_clock_i,
    input  logic                 rst_i,
    input  logic                 load_i,
    input  burst_t               burst_i,
    output logic [DATA_BITS-1:0] dq_o
);

    lane_t shift_q;

    assign dq_o = shift_q[DATA_BITS-1:0];   // Lowest beat drives the pins

    always_ff @(posedge ddr_clock_i) begin
        if (rst_i) begin
            shift_q <= '0;
        end else if (load_i) begin
            for (int b = 0; b < HALF_BURST; b++) begin
                shift_q[b*DATA_BITS +: DATA_BITS] <=
                    burst_i[(b*NUM_LANES + LANE_INDEX)*DATA_BITS +: DATA_BITS];
            end
        end else begin
            // Zeros fill in from the top
            shift_q <= {{DATA_BITS{1'b0}}, shift_q[HALF_BURST*DATA_BITS-1:DATA_BITS]};
        end
    end

endmodule

// ==== source/refresh_timer.sv ====
`timescale 1ns/100ps

module refresh_timer import ddr_pkg::*; (
    input  logic ddr_clock_i,
    input  logic rst_i,
    input  logic refresh_ack_i,
    output logic refresh_req_o
);

    logic [$clog2(T_REFI+1)-1:0] count;

    // Request stays up until the sequencer issues REFRESH
    always_ff @(posedge ddr_clock_i) begin
        if (rst_i) begin
            count         <= ($clog2(T_REFI+1))'(T_REFI);
            refresh_req_o <= 1'b0;
        end else if (refresh_ack_i) begin
            count         <= ($clog2(T_REFI+1))'(T_REFI);
            refresh_req_o <= 1'b0;
        end else if (count == '0) begin
            refresh_req_o <= 1'b1;
        end else begin
            count <= count - 1'b1;
        end
    end

endmodule

// ==== source/ddr_pkg.sv ====
package ddr_pkg;

    // Memory geometry
    localparam int BANK_BITS     = 3;
    localparam int ROW_BITS      = 14;
    localparam int COL_BITS      = 10;
    localparam int DATA_BITS     = 16;
    localparam int BURST_LENGTH  = 8;
    localparam int HALF_BURST    = BURST_LENGTH / 2;   // Beats per lane
    localparam int NUM_LANES     = 2;
    localparam int BURST_BITS    = BURST_LENGTH * DATA_BITS;
    localparam int ADDR_PIN_BITS = 14;

    // Timing in ddr clock cycles
    localparam int T_RCD             = 3;
    localparam int T_RP              = 3;
    localparam int T_WR              = 2;   // Write recovery
    localparam int T_RFC             = 8;
    localparam int T_REFI            = 200;
    localparam int CAS_READ_LATENCY  = 5;
    localparam int CAS_WRITE_LATENCY = 5;
    localparam int WAIT_BITS         = 4;

    typedef struct packed {
        logic                 write;
        logic [BANK_BITS-1:0] bank;
        logic [ROW_BITS-1:0]  row;
        logic [COL_BITS-1:0]  col;
    } ddr_req_t;

    typedef struct packed {
        logic cs_n;
        logic ras_n;
        logic cas_n;
        logic we_n;
    } ddr_pin_cmd_t;

    typedef logic [BURST_BITS-1:0] burst_t;
    typedef logic [HALF_BURST*DATA_BITS-1:0] lane_t;

    // JEDEC encodings in CS RAS CAS WE order
    localparam ddr_pin_cmd_t CMD_NOP      = 4'b0111;
    localparam ddr_pin_cmd_t CMD_ACTIVATE = 4'b0011;
    localparam ddr_pin_cmd_t CMD_READ     = 4'b0101;
    localparam ddr_pin_cmd_t CMD_WRITE    = 4'b0100;
    localparam ddr_pin_cmd_t CMD_REFRESH  = 4'b0001;

endpackage
